//--- src/csr_settings.svh
// Architecture settings of the machine-mode CSR unit
// Included by the package and by any module that needs a raw setting

`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Data width of CSRs and integer registers
// Only 32 is supported by the mstatus layout
`define CSR_XLEN 32

// Hart number returned by mhartid
`define CSR_MHART_ID 0

// Extension flags reported in misa
// Each one is 0 or 1
`define CSR_M_EXT 1
`define CSR_F_EXT 0
// Reduced register file base ISA
`define CSR_RV32E 0

// Flops per interrupt line synchronizer
`define CSR_SYNC_DEPTH 2

`endif

//--- src/csr_pkg.sv
// Shared types, CSR addresses and field positions of the CSR unit
// Imported by the sequencer, the register storage and the top level

`include "csr_settings.svh"

package csr_pkg;

    // Field widths
    localparam int FUNCT3_W   = 3;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;

    typedef logic [`CSR_XLEN-1:0] xlen_t;
    // Also carries the zimm immediate
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Implemented machine CSRs
    typedef enum logic [CSR_ADDR_W-1:0] {
        MSTATUS  = 12'h300,
        MISA     = 12'h301,
        MIE      = 12'h304,
        MTVEC    = 12'h305,
        MSCRATCH = 12'h340,
        MEPC     = 12'h341,
        MCAUSE   = 12'h342,
        MTVAL    = 12'h343,
        MIP      = 12'h344,
        MHARTID  = 12'hF14
    } csr_addr_e;

    // Zicsr funct3 encodings
    typedef enum logic [FUNCT3_W-1:0] {
        CSRRW  = 3'd1,
        CSRRS  = 3'd2,
        CSRRC  = 3'd3,
        CSRRWI = 3'd5,
        CSRRSI = 3'd6,
        CSRRCI = 3'd7
    } csr_op_e;

    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        STORE
    } csr_state_e;

    // mstatus / mie / mip bit positions
    localparam int MSTATUS_MIE_BIT = 3;
    localparam int MIP_MSI_BIT     = 3;
    localparam int MIP_MTI_BIT     = 7;
    localparam int MIP_MEI_BIT     = 11;

    // WPRI fields 30:23, 10:9, 6 and 2 read as zero
    localparam xlen_t MSTATUS_WMASK = 32'h807F_F9BB;

    // Instruction field LSBs
    localparam int RD_POS     = 7;
    localparam int FUNCT3_POS = 12;
    localparam int RS1_POS    = 15;
    localparam int CSR_POS    = 20;

    // misa built from the extension flags with MXL=1 for 32 bits
    function automatic xlen_t misa_value();
        xlen_t value;
        value        = '0;
        value[31:30] = 2'b01;
        value[4]     = (`CSR_RV32E != 0);
        value[5]     = (`CSR_F_EXT != 0);
        value[8]     = (`CSR_RV32E == 0);
        value[12]    = (`CSR_M_EXT != 0);
        return value;
    endfunction

endpackage

//--- src/csr_exec_fsm.sv
// Zicsr instruction sequencer of the CSR unit
// Accepts one instruction, reads the old CSR value, writes rd and the new CSR value

`timescale 1ns/10ps

module csr_exec_fsm (
    input  logic                aclk,
    input  logic                aresetn,
    // Instruction handshake
    input  logic                valid,
    output logic                ready,
    input  csr_pkg::xlen_t      instbus,
    // Register file read
    output csr_pkg::reg_addr_t  rs1_addr,
    input  csr_pkg::xlen_t      rs1_val,
    // Register file write
    output logic                rd_wr_en,
    output csr_pkg::reg_addr_t  rd_wr_addr,
    output csr_pkg::xlen_t      rd_wr_val,
    // CSR storage read port
    output logic                csr_rd_en,
    output csr_pkg::csr_addr_e  csr_rd_addr,
    input  csr_pkg::xlen_t      csr_rd_data,
    // CSR storage write port
    output logic                csr_wr_en,
    output csr_pkg::csr_addr_e  csr_wr_addr,
    output csr_pkg::xlen_t      csr_wr_data
);

    import csr_pkg::*;

    csr_state_e state;
    logic       accept;

    // Latched instruction fields
    csr_op_e    funct3_r;
    // rs1 index and zimm share bits 19:15
    reg_addr_t  src_idx_r;
    xlen_t      rs1_val_r;

    // Operation result
    xlen_t      src_val;
    xlen_t      new_val;
    logic       wr_apply;

    //////////////////////////////////////////////////
    // Instruction decode
    //////////////////////////////////////////////////

    // Register file answers rs1 in the same cycle
    assign rs1_addr    = instbus[RS1_POS +: REG_ADDR_W];
    assign csr_rd_addr = csr_addr_e'(instbus[CSR_POS +: CSR_ADDR_W]);

    // Handshake on IDLE only
    assign accept    = (state == IDLE) && valid && ready;
    // Storage samples the old value on the accepting edge
    assign csr_rd_en = accept;

    //////////////////////////////////////////////////
    // New value
    //////////////////////////////////////////////////

    // Immediate forms have funct3[2] set
    assign src_val = funct3_r[2] ? xlen_t'(src_idx_r) : rs1_val_r;

    always_comb begin
        new_val  = csr_rd_data;
        wr_apply = 1'b0;
        case (funct3_r)
            // Swap always writes
            CSRRW, CSRRWI: begin
                new_val  = src_val;
                wr_apply = 1'b1;
            end
            // x0 or zimm of zero means read only
            CSRRS, CSRRSI: begin
                new_val  = csr_rd_data | src_val;
                wr_apply = (src_idx_r != '0);
            end
            CSRRC, CSRRCI: begin
                new_val  = csr_rd_data & ~src_val;
                wr_apply = (src_idx_r != '0);
            end
            // Reserved funct3 leaves the CSR alone
            default: begin
                new_val  = csr_rd_data;
                wr_apply = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= IDLE;
            ready     <= 1'b0;
            rd_wr_en  <= 1'b0;
            csr_wr_en <= 1'b0;
        end else begin
            // Write strobes are single pulses
            rd_wr_en  <= 1'b0;
            csr_wr_en <= 1'b0;
            case (state)
                IDLE: begin
                    ready <= 1'b1;
                    if (accept) begin
                        ready <= 1'b0;
                        state <= COMPUTE;
                    end
                end
                // Old value is in csr_rd_data here
                COMPUTE: begin
                    rd_wr_en  <= 1'b1;
                    csr_wr_en <= wr_apply;
                    state     <= STORE;
                end
                // CSR commits on this edge
                STORE: begin
                    ready <= 1'b1;
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Operand and result registers
    always_ff @(posedge aclk) begin
        if (accept) begin
            funct3_r    <= csr_op_e'(instbus[FUNCT3_POS +: FUNCT3_W]);
            src_idx_r   <= rs1_addr;
            rs1_val_r   <= rs1_val;
            rd_wr_addr  <= instbus[RD_POS +: REG_ADDR_W];
            csr_wr_addr <= csr_rd_addr;
        end
        if (state == COMPUTE) begin
            // rd always gets the old value
            rd_wr_val   <= csr_rd_data;
            csr_wr_data <= new_val;
        end
    end

endmodule

//--- src/csr_machine_regs.sv
// Machine-mode CSR storage with trap writes, interrupt pending logic and read port
// Driven by the sequencer read and write ports and by the trap controller

`timescale 1ns/10ps

`include "csr_settings.svh"

module csr_machine_regs (
    input  logic                aclk,
    input  logic                aresetn,
    // Asynchronous interrupt levels
    input  logic                ext_irq,
    input  logic                timer_irq,
    input  logic                sw_irq,
    // Sequencer read port
    input  logic                csr_rd_en,
    input  csr_pkg::csr_addr_e  csr_rd_addr,
    output csr_pkg::xlen_t      csr_rd_data,
    // Sequencer write port
    input  logic                csr_wr_en,
    input  csr_pkg::csr_addr_e  csr_wr_addr,
    input  csr_pkg::xlen_t      csr_wr_data,
    // Trap controller writes
    input  logic                ctrl_mepc_wr,
    input  csr_pkg::xlen_t      ctrl_mepc,
    input  logic                ctrl_mstatus_wr,
    input  csr_pkg::xlen_t      ctrl_mstatus,
    input  logic                ctrl_mcause_wr,
    input  csr_pkg::xlen_t      ctrl_mcause,
    input  logic                ctrl_mtval_wr,
    input  csr_pkg::xlen_t      ctrl_mtval,
    // Shared CSR signals
    output csr_pkg::xlen_t      mtvec,
    output csr_pkg::xlen_t      mepc,
    output csr_pkg::xlen_t      mstatus,
    output logic                meip,
    output logic                mtip,
    output logic                msip
);

    import csr_pkg::*;

    // Read-only values
    localparam xlen_t MISA_VAL    = misa_value();
    localparam xlen_t MHARTID_VAL = xlen_t'(`CSR_MHART_ID);
    // IALIGN=32 so mepc[1:0] is zero
    localparam xlen_t MEPC_MASK   = ~xlen_t'(3);

    xlen_t mie;
    xlen_t mscratch;
    xlen_t mcause;
    xlen_t mtval;
    xlen_t mip;

    // Per-register instruction write enables
    logic  wr_mstatus;
    logic  wr_mie;
    logic  wr_mtvec;
    logic  wr_mscratch;
    logic  wr_mepc;
    logic  wr_mcause;
    logic  wr_mtval;
    logic  wr_mip;

    // Synchronizer stages holding {ext, timer, sw}
    logic [2:0] irq_sync_q [`CSR_SYNC_DEPTH];
    logic [2:0] irq_sync;
    logic       irq_en;

    //////////////////////////////////////////////////
    // Write address decode
    //////////////////////////////////////////////////

    always_comb begin
        wr_mstatus  = 1'b0;
        wr_mie      = 1'b0;
        wr_mtvec    = 1'b0;
        wr_mscratch = 1'b0;
        wr_mepc     = 1'b0;
        wr_mcause   = 1'b0;
        wr_mtval    = 1'b0;
        wr_mip      = 1'b0;
        if (csr_wr_en) begin
            case (csr_wr_addr)
                MSTATUS:  wr_mstatus  = 1'b1;
                MIE:      wr_mie      = 1'b1;
                MTVEC:    wr_mtvec    = 1'b1;
                MSCRATCH: wr_mscratch = 1'b1;
                MEPC:     wr_mepc     = 1'b1;
                MCAUSE:   wr_mcause   = 1'b1;
                MTVAL:    wr_mtval    = 1'b1;
                MIP:      wr_mip      = 1'b1;
                // misa, mhartid and unknown addresses drop the write
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Writable CSRs
    //////////////////////////////////////////////////

    // Trap controller wins over the instruction
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else begin
            if (ctrl_mstatus_wr) begin
                mstatus <= ctrl_mstatus & MSTATUS_WMASK;
            end else if (wr_mstatus) begin
                mstatus <= csr_wr_data & MSTATUS_WMASK;
            end
            if (ctrl_mepc_wr) begin
                mepc <= ctrl_mepc & MEPC_MASK;
            end else if (wr_mepc) begin
                mepc <= csr_wr_data & MEPC_MASK;
            end
            if (ctrl_mcause_wr) begin
                mcause <= ctrl_mcause;
            end else if (wr_mcause) begin
                mcause <= csr_wr_data;
            end
            if (ctrl_mtval_wr) begin
                mtval <= ctrl_mtval;
            end else if (wr_mtval) begin
                mtval <= csr_wr_data;
            end
            // Instruction-only registers
            if (wr_mie) begin
                mie <= csr_wr_data;
            end
            if (wr_mtvec) begin
                mtvec <= csr_wr_data;
            end
            if (wr_mscratch) begin
                mscratch <= csr_wr_data;
            end
        end
    end

    //////////////////////////////////////////////////
    // Interrupt synchronizers and pending bits
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < `CSR_SYNC_DEPTH; i++) begin
                irq_sync_q[i] <= '0;
            end
        end else begin
            irq_sync_q[0] <= {ext_irq, timer_irq, sw_irq};
            for (int i = 1; i < `CSR_SYNC_DEPTH; i++) begin
                irq_sync_q[i] <= irq_sync_q[i-1];
            end
        end
    end

    assign irq_sync = irq_sync_q[`CSR_SYNC_DEPTH-1];
    // Global machine interrupt enable
    assign irq_en   = mstatus[MSTATUS_MIE_BIT];

    // Lines override instruction writes while any is high
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mip <= '0;
        end else if (|irq_sync) begin
            mip[MIP_MEI_BIT] <= irq_sync[2] & mie[MIP_MEI_BIT] & irq_en;
            mip[MIP_MTI_BIT] <= irq_sync[1] & mie[MIP_MTI_BIT] & irq_en;
            mip[MIP_MSI_BIT] <= irq_sync[0] & mie[MIP_MSI_BIT] & irq_en;
        end else if (wr_mip) begin
            mip <= csr_wr_data;
        end
    end

    assign meip = mip[MIP_MEI_BIT];
    assign mtip = mip[MIP_MTI_BIT];
    assign msip = mip[MIP_MSI_BIT];

    //////////////////////////////////////////////////
    // Registered read port
    //////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (csr_rd_en) begin
            case (csr_rd_addr)
                MSTATUS:  csr_rd_data <= mstatus;
                MISA:     csr_rd_data <= MISA_VAL;
                MIE:      csr_rd_data <= mie;
                MTVEC:    csr_rd_data <= mtvec;
                MSCRATCH: csr_rd_data <= mscratch;
                MEPC:     csr_rd_data <= mepc;
                MCAUSE:   csr_rd_data <= mcause;
                MTVAL:    csr_rd_data <= mtval;
                MIP:      csr_rd_data <= mip;
                MHARTID:  csr_rd_data <= MHARTID_VAL;
                // Unimplemented CSRs read as zero
                default:  csr_rd_data <= '0;
            endcase
        end
    end

endmodule

//--- src/csr_unit_top.sv
// Top level of the machine-mode CSR unit
// Joins the instruction sequencer to the CSR storage and exposes the core ports

`timescale 1ns/10ps

module csr_unit_top (
    input  logic                aclk,
    input  logic                aresetn,
    // Interrupt lines
    input  logic                ext_irq,
    input  logic                timer_irq,
    input  logic                sw_irq,
    // Instruction bus
    input  logic                valid,
    output logic                ready,
    input  csr_pkg::xlen_t      instbus,
    // Register file
    output csr_pkg::reg_addr_t  rs1_addr,
    input  csr_pkg::xlen_t      rs1_val,
    output logic                rd_wr_en,
    output csr_pkg::reg_addr_t  rd_wr_addr,
    output csr_pkg::xlen_t      rd_wr_val,
    // Trap controller
    input  logic                ctrl_mepc_wr,
    input  csr_pkg::xlen_t      ctrl_mepc,
    input  logic                ctrl_mstatus_wr,
    input  csr_pkg::xlen_t      ctrl_mstatus,
    input  logic                ctrl_mcause_wr,
    input  csr_pkg::xlen_t      ctrl_mcause,
    input  logic                ctrl_mtval_wr,
    input  csr_pkg::xlen_t      ctrl_mtval,
    // Shared CSR signals
    output csr_pkg::xlen_t      mtvec,
    output csr_pkg::xlen_t      mepc,
    output csr_pkg::xlen_t      mstatus,
    output logic                meip,
    output logic                mtip,
    output logic                msip
);

    import csr_pkg::*;

    // Sequencer to storage
    logic      csr_rd_en;
    csr_addr_e csr_rd_addr;
    xlen_t     csr_rd_data;
    logic      csr_wr_en;
    csr_addr_e csr_wr_addr;
    xlen_t     csr_wr_data;

    csr_exec_fsm u_exec_fsm (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .valid       (valid),
        .ready       (ready),
        .instbus     (instbus),
        .rs1_addr    (rs1_addr),
        .rs1_val     (rs1_val),
        .rd_wr_en    (rd_wr_en),
        .rd_wr_addr  (rd_wr_addr),
        .rd_wr_val   (rd_wr_val),
        .csr_rd_en   (csr_rd_en),
        .csr_rd_addr (csr_rd_addr),
        .csr_rd_data (csr_rd_data),
        .csr_wr_en   (csr_wr_en),
        .csr_wr_addr (csr_wr_addr),
        .csr_wr_data (csr_wr_data)
    );

    csr_machine_regs u_machine_regs (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .ext_irq         (ext_irq),
        .timer_irq       (timer_irq),
        .sw_irq          (sw_irq),
        .csr_rd_en       (csr_rd_en),
        .csr_rd_addr     (csr_rd_addr),
        .csr_rd_data     (csr_rd_data),
        .csr_wr_en       (csr_wr_en),
        .csr_wr_addr     (csr_wr_addr),
        .csr_wr_data     (csr_wr_data),
        .ctrl_mepc_wr    (ctrl_mepc_wr),
        .ctrl_mepc       (ctrl_mepc),
        .ctrl_mstatus_wr (ctrl_mstatus_wr),
        .ctrl_mstatus    (ctrl_mstatus),
        .ctrl_mcause_wr  (ctrl_mcause_wr),
        .ctrl_mcause     (ctrl_mcause),
        .ctrl_mtval_wr   (ctrl_mtval_wr),
        .ctrl_mtval      (ctrl_mtval),
        .mtvec           (mtvec),
        .mepc            (mepc),
        .mstatus         (mstatus),
        .meip            (meip),
        .mtip            (mtip),
        .msip            (msip)
    );

endmodule

//--- testbench/csr_unit_assert.sv
// Handshake and write-back timing assertions for the CSR unit top level
// Attached to csr_unit_top by the bind at the end of this file

`timescale 1ns/10ps

module csr_unit_assert (
    input logic aclk,
    input logic aresetn,
    input logic valid,
    input logic ready,
    input logic rd_wr_en
);

    logic accept;

    assign accept = valid && ready;

    // Write-back strobe is a single pulse
    a_rd_pulse: assert property (
        @(posedge aclk) disable iff (!aresetn) rd_wr_en |=> !rd_wr_en
    ) else $error("rd_wr_en stayed high for two cycles");

    // Two edges from acceptance to write-back, and no write-back without one
    a_rd_after_accept: assert property (
        @(posedge aclk) disable iff (!aresetn) rd_wr_en == $past(accept, 2)
    ) else $error("rd_wr_en not two edges after an acceptance");

    a_ready_low: assert property (
        @(posedge aclk) disable iff (!aresetn) rd_wr_en |-> !ready
    ) else $error("ready high during write-back");

    // Quiet while reset is held
    a_reset_quiet: assert property (
        @(posedge aclk) !aresetn |-> (!ready && !rd_wr_en)
    ) else $error("ready or rd_wr_en high during reset");

endmodule

bind csr_unit_top csr_unit_assert u_csr_unit_assert (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .valid    (valid),
    .ready    (ready),
    .rd_wr_en (rd_wr_en)
);

//--- testbench/tb_csr_tests.svh
// Directed tests of the CSR unit, included inside the testbench top
// Each task drives instructions or trap strobes and checks the responses

`ifndef TB_CSR_TESTS_SVH
`define TB_CSR_TESTS_SVH

// Read with CSRRS rd, x0 and compare
task automatic expect_csr(input string what, input logic [11:0] addr, input xlen_t expected);
    xlen_t got;
    issue_csr(encode_csr(CSRRS, addr, 5'd0, 5'd31), got);
    check_word(what, expected, got);
endtask

// rd always receives the old value
task automatic exec_csr(input string what, input csr_op_e op, input logic [11:0] addr,
                        input reg_addr_t src, input xlen_t expected_old);
    xlen_t got;
    issue_csr(encode_csr(op, addr, src, 5'd20), got);
    check_word(what, expected_old, got);
endtask

task automatic test_reset_values();
    logic [11:0] writable [8];
    test_name = "reset_values";
    writable  = '{12'h300, 12'h304, 12'h305, 12'h340, 12'h341, 12'h342, 12'h343, 12'h344};
    foreach (writable[i]) begin
        expect_csr($sformatf("csr %h", writable[i]), writable[i], '0);
    end
    expect_csr("misa", 12'h301, misa_expected());
    expect_csr("mhartid", 12'hF14, xlen_t'(`CSR_MHART_ID));
    // medeleg is left out of the map
    expect_csr("medeleg", 12'h302, '0);
    expect_csr("unknown", 12'h7C0, '0);
endtask

task automatic test_swap();
    logic [11:0] addrs [2];
    xlen_t       model;
    xlen_t       value;
    reg_addr_t   zimm;
    test_name = "swap";
    addrs     = '{12'h340, 12'h305};
    foreach (addrs[a]) begin
        model = '0;
        repeat (3) begin
            value = rand_bits(32);
            set_reg(5'd5, value);
            exec_csr("csrrw old", CSRRW, addrs[a], 5'd5, model);
            expect_csr("csrrw new", addrs[a], value);
            model = rand_bits(5);
            zimm  = model[4:0];
            exec_csr("csrrwi old", CSRRWI, addrs[a], zimm, value);
            expect_csr("csrrwi new", addrs[a], model);
            if (addrs[a] == 12'h305) begin
                check_word("mtvec port", model, mtvec);
            end
        end
    end
endtask

task automatic test_set_clear();
    xlen_t     model;
    xlen_t     mask;
    reg_addr_t zimm;
    test_name = "set_clear";
    model     = rand_bits(32);
    set_reg(5'd1, model);
    issue_csr(encode_csr(CSRRW, 12'h340, 5'd1, 5'd20), mask);
    repeat (4) begin
        mask = rand_bits(32);
        set_reg(5'd2, mask);
        exec_csr("csrrs", CSRRS, 12'h340, 5'd2, model);
        model = model | mask;
        mask  = rand_bits(32);
        set_reg(5'd3, mask);
        exec_csr("csrrc", CSRRC, 12'h340, 5'd3, model);
        model = model & ~mask;
        mask  = rand_bits(5);
        zimm  = mask[4:0];
        exec_csr("csrrsi", CSRRSI, 12'h340, zimm, model);
        model = model | xlen_t'(zimm);
        mask  = rand_bits(5);
        zimm  = mask[4:0];
        exec_csr("csrrci", CSRRCI, 12'h340, zimm, model);
        model = model & ~xlen_t'(zimm);
    end
    // Source of zero reads without a write
    exec_csr("csrrs x0", CSRRS, 12'h340, 5'd0, model);
    exec_csr("csrrc x0", CSRRC, 12'h340, 5'd0, model);
    exec_csr("csrrsi 0", CSRRSI, 12'h340, 5'd0, model);
    exec_csr("csrrci 0", CSRRCI, 12'h340, 5'd0, model);
    expect_csr("unchanged", 12'h340, model);
endtask

task automatic test_field_masks();
    xlen_t value;
    xlen_t keep;
    test_name = "field_masks";
    set_reg(5'd4, '1);
    exec_csr("mstatus old", CSRRW, 12'h300, 5'd4, '0);
    expect_csr("mstatus ones", 12'h300, MSTATUS_RW);
    check_word("mstatus port", MSTATUS_RW, mstatus);
    value = rand_bits(32);
    set_reg(5'd4, value);
    exec_csr("mepc old", CSRRW, 12'h341, 5'd4, '0);
    expect_csr("mepc align", 12'h341, value & ~xlen_t'(3));
    check_word("mepc port", value & ~xlen_t'(3), mepc);
    // Unknown address and misa drop the write
    keep = rand_bits(32);
    set_reg(5'd5, keep);
    exec_csr("mcause old", CSRRW, 12'h342, 5'd5, '0);
    exec_csr("unknown old", CSRRW, 12'h7C0, 5'd4, '0);
    expect_csr("unknown after", 12'h7C0, '0);
    exec_csr("misa old", CSRRW, 12'h301, 5'd4, misa_expected());
    expect_csr("misa kept", 12'h301, misa_expected());
    expect_csr("mcause kept", 12'h342, keep);
endtask

// Strobe order is mepc, mstatus, mcause, mtval
task automatic pulse_trap(input int sel, input xlen_t value);
    @(posedge aclk);
    ctrl_mepc       <= value;
    ctrl_mstatus    <= value;
    ctrl_mcause     <= value;
    ctrl_mtval      <= value;
    ctrl_mepc_wr    <= (sel == 0);
    ctrl_mstatus_wr <= (sel == 1);
    ctrl_mcause_wr  <= (sel == 2);
    ctrl_mtval_wr   <= (sel == 3);
    @(posedge aclk);
    ctrl_mepc_wr    <= 1'b0;
    ctrl_mstatus_wr <= 1'b0;
    ctrl_mcause_wr  <= 1'b0;
    ctrl_mtval_wr   <= 1'b0;
endtask

task automatic test_trap_writes();
    xlen_t value [4];
    test_name = "trap_writes";
    foreach (value[i]) begin
        value[i] = rand_bits(32);
        pulse_trap(i, value[i]);
    end
    @(negedge aclk);
    check_word("mepc port", value[0] & ~xlen_t'(3), mepc);
    check_word("mstatus port", value[1] & MSTATUS_RW, mstatus);
    expect_csr("mepc", 12'h341, value[0] & ~xlen_t'(3));
    expect_csr("mstatus", 12'h300, value[1] & MSTATUS_RW);
    expect_csr("mcause", 12'h342, value[2]);
    expect_csr("mtval", 12'h343, value[3]);
endtask

// Line 0 is software, 1 timer, 2 external
task automatic drive_irq(input int line, input logic level);
    @(posedge aclk);
    case (line)
        0:       sw_irq    <= level;
        1:       timer_irq <= level;
        default: ext_irq   <= level;
    endcase
endtask

function automatic logic pending_bit(input int line);
    logic [2:0] bits;
    bits = {meip, mtip, msip};
    return bits[line];
endfunction

// Pending must show within 10 cycles
task automatic watch_pending(input int line, output logic seen);
    seen = 1'b0;
    for (int i = 0; i < 10; i++) begin
        @(negedge aclk);
        seen = seen | pending_bit(line);
    end
endtask

task automatic test_interrupts();
    logic  seen;
    xlen_t dummy;
    test_name = "interrupts";
    // mie bits 11, 7 and 3
    set_reg(5'd6, 32'h0000_0888);
    issue_csr(encode_csr(CSRRW, 12'h304, 5'd6, 5'd20), dummy);
    issue_csr(encode_csr(CSRRW, 12'h300, 5'd0, 5'd20), dummy);
    exec_csr("mstatus set mie", CSRRSI, 12'h300, 5'd8, '0);
    for (int line = 0; line < 3; line++) begin
        drive_irq(line, 1'b1);
        watch_pending(line, seen);
        check_bit($sformatf("line %0d raised", line), 1'b1, seen);
        drive_irq(line, 1'b0);
        // Low level has to clear the synchronizer first
        repeat (`CSR_SYNC_DEPTH + 2) @(posedge aclk);
        issue_csr(encode_csr(CSRRW, 12'h344, 5'd0, 5'd20), dummy);
        @(negedge aclk);
        check_bit($sformatf("line %0d cleared", line), 1'b0, pending_bit(line));
    end
    // Global enable off
    exec_csr("mstatus clear mie", CSRRCI, 12'h300, 5'd8, 32'h0000_0008);
    for (int line = 0; line < 3; line++) begin
        drive_irq(line, 1'b1);
        watch_pending(line, seen);
        check_bit($sformatf("line %0d masked", line), 1'b0, seen);
        drive_irq(line, 1'b0);
    end
endtask

`endif

//--- testbench/tb_csr_unit.sv
// Testbench top for the CSR unit with clock, reset, register file model and checks
// Built from sources.f and pulls in the directed tests from tb_csr_tests.svh

`timescale 1ns/10ps

`include "csr_settings.svh"

module tb_csr_unit;

    import csr_pkg::*;

    // mstatus bits 30:23, 10:9, 6 and 2 are hardwired to zero
    localparam xlen_t MSTATUS_RW = ~(32'h7F80_0000 | 32'h0000_0600 | 32'h0000_0044);

    logic      aclk;
    logic      aresetn;
    logic      ext_irq;
    logic      timer_irq;
    logic      sw_irq;
    logic      valid;
    logic      ready;
    xlen_t     instbus;
    reg_addr_t rs1_addr;
    xlen_t     rs1_val;
    logic      rd_wr_en;
    reg_addr_t rd_wr_addr;
    xlen_t     rd_wr_val;
    logic      ctrl_mepc_wr;
    xlen_t     ctrl_mepc;
    logic      ctrl_mstatus_wr;
    xlen_t     ctrl_mstatus;
    logic      ctrl_mcause_wr;
    xlen_t     ctrl_mcause;
    logic      ctrl_mtval_wr;
    xlen_t     ctrl_mtval;
    xlen_t     mtvec;
    xlen_t     mepc;
    xlen_t     mstatus;
    logic      meip;
    logic      mtip;
    logic      msip;

    // Register file model where x0 is never written
    xlen_t       regfile [32];
    logic [31:0] lfsr_state;
    string       test_name;
    int          error_cnt;
    int          check_cnt;
    int          issued_cnt;
    int          cycle_cnt;

    assign rs1_val = regfile[rs1_addr];

    csr_unit_top u_csr_unit_top (.*);

    initial begin
        aclk = 1'b0;
        forever begin
            #4 aclk = ~aclk;
        end
    end

    //////////////////////////////////////////////////
    // Random data and instruction encoding
    //////////////////////////////////////////////////

    // Fibonacci LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic xlen_t rand_bits(input int n);
        xlen_t value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value[i] = lfsr_bit();
        end
        return value;
    endfunction

    // SYSTEM major opcode with the Zicsr fields
    function automatic xlen_t encode_csr(input csr_op_e op, input logic [11:0] addr,
                                         input reg_addr_t src, input reg_addr_t rd);
        return {addr, src, op, rd, 7'b1110011};
    endfunction

    // MXL of 1 selects 32 bits
    function automatic xlen_t misa_expected();
        xlen_t value;
        value = 32'h4000_0000;
        if (`CSR_RV32E != 0) begin
            value = value | 32'h0000_0010;
        end else begin
            value = value | 32'h0000_0100;
        end
        if (`CSR_M_EXT != 0) begin
            value = value | 32'h0000_1000;
        end
        if (`CSR_F_EXT != 0) begin
            value = value | 32'h0000_0020;
        end
        return value;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_word(input string what, input xlen_t expected, input xlen_t actual);
        check_cnt++;
        if (actual !== expected) begin
            error_cnt++;
            $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        check_cnt++;
        if (actual !== expected) begin
            error_cnt++;
            $display("Error: %s %s expected %b actual %b", test_name, what, expected, actual);
        end
    endtask

    task automatic check_addr(input string what, input reg_addr_t expected,
                              input reg_addr_t actual);
        check_cnt++;
        if (actual !== expected) begin
            error_cnt++;
            $display("Error: %s %s expected x%0d actual x%0d", test_name, what,
                     expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // Bus tasks
    //////////////////////////////////////////////////

    task automatic set_reg(input reg_addr_t idx, input xlen_t value);
        @(posedge aclk);
        if (idx != '0) begin
            regfile[idx] <= value;
        end
    endtask

    // One instruction through the handshake that returns the rd value
    task automatic issue_csr(input xlen_t inst, output xlen_t result);
        issued_cnt++;
        @(posedge aclk);
        valid   <= 1'b1;
        instbus <= inst;
        // Accepted on the next rising edge that sees ready
        @(negedge aclk);
        while (!ready) begin
            @(negedge aclk);
        end
        // rs1 index is decoded straight from the bus
        check_addr("rs1 index", inst[19:15], rs1_addr);
        @(posedge aclk);
        valid <= 1'b0;
        @(negedge aclk);
        while (!rd_wr_en) begin
            @(negedge aclk);
        end
        result = rd_wr_val;
        check_addr("rd index", inst[11:7], rd_wr_addr);
        // Write-back lands on the edge that ends the pulse
        @(posedge aclk);
        if (rd_wr_addr != '0) begin
            regfile[rd_wr_addr] <= rd_wr_val;
        end
    endtask

    `include "tb_csr_tests.svh"

    //////////////////////////////////////////////////
    // Test sequence and verdict
    //////////////////////////////////////////////////

    initial begin
        aresetn         = 1'b0;
        valid           = 1'b0;
        instbus         = '0;
        ext_irq         = 1'b0;
        timer_irq       = 1'b0;
        sw_irq          = 1'b0;
        ctrl_mepc_wr    = 1'b0;
        ctrl_mepc       = '0;
        ctrl_mstatus_wr = 1'b0;
        ctrl_mstatus    = '0;
        ctrl_mcause_wr  = 1'b0;
        ctrl_mcause     = '0;
        ctrl_mtval_wr   = 1'b0;
        ctrl_mtval      = '0;
        lfsr_state      = 32'hf3ce2fdd;
        error_cnt       = 0;
        check_cnt       = 0;
        issued_cnt      = 0;
        foreach (regfile[i]) begin
            regfile[i] = '0;
        end
        repeat (3) @(posedge aclk);
        aresetn <= 1'b1;
        test_reset_values();
        test_swap();
        test_set_clear();
        test_field_masks();
        test_trap_writes();
        test_interrupts();
        $display("Done: %0d checks, %0d errors", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Budget grows by 40 cycles with each issued instruction
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < 40 * issued_cnt + 500) begin
            @(posedge aclk);
            cycle_cnt++;
        end
        $display("Timeout: run stopped after %0d cycles, %0d instructions issued, %0d errors",
                 cycle_cnt, issued_cnt, error_cnt);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- sources.f
+incdir+src
+incdir+testbench
src/csr_pkg.sv
src/csr_exec_fsm.sv
src/csr_machine_regs.sv
src/csr_unit_top.sv
testbench/csr_unit_assert.sv
testbench/tb_csr_unit.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_csr_unit
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check for the pass line"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
